// ==== tests/sched_input.txt ====
// one dispatch per line, hex digits: test op rd rs1 rs2
// op 0 add, 1 sub, 2 xor, 3 and; register n starts at n
10812
11912
12A53
13B7E
20C99
21D1F
30E8C
30FEE
321FA
33456
30213
40544
41652
40733
50987
50A99
50BAA
50CBB
50DCC
52E12
53F56
50315
51426

// ==== build.f ====
rtl/sched_pkg.sv
rtl/sched_entry.sv
rtl/issue_queue.sv
rtl/alu_pipe.sv
rtl/phys_regfile.sv
rtl/commit_unit.sv
rtl/sched_top.sv
tests/sched_checker.sv
tests/tb_sched.sv

// ==== Bender.yml ====
package:
  name: sched

sources:
  - rtl/sched_pkg.sv
  - rtl/sched_entry.sv
  - rtl/issue_queue.sv
  - rtl/alu_pipe.sv
  - rtl/phys_regfile.sv
  - rtl/commit_unit.sv
  - rtl/sched_top.sv
  - target: test
    files:
      - tests/sched_checker.sv
      - tests/tb_sched.sv

// ==== tests/tb_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sched;

  localparam int MAX_LINES = 64;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 disp_valid;
  sched_pkg::disp_t     disp;
  logic                 disp_ready;
  sched_pkg::wb_t       wb;
  sched_pkg::commit_t   commit;
  logic [3:0]           disp_test;
  logic                 disp_last;

  logic [19:0] lines [MAX_LINES];  // test, op, rd, rs1, rs2 as hex digits
  int          num_lines;
  int          limit;
  int          cycles;
  int          seed;
  logic [15:0] busy;               // renamer busy table
  int          readers [16];       // pending source reads per register
  logic [3:0]  src1 [8];
  logic [3:0]  src2 [8];
  logic [2:0]  next_id;
  int          errors;
  int          tests_pass;
  int          tests_fail;
  int          commits;
  int          stalls;

  sched_top dut_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (disp_valid),
    .i_disp       (disp),
    .o_disp_ready (disp_ready),
    .o_wb         (wb),
    .o_commit     (commit)
  );

  sched_checker checker_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (disp_valid),
    .i_disp_ready (disp_ready),
    .i_disp       (disp),
    .i_test       (disp_test),
    .i_last       (disp_last),
    .i_wb         (wb),
    .i_commit     (commit),
    .o_errors     (errors),
    .o_tests_pass (tests_pass),
    .o_tests_fail (tests_fail),
    .o_commits    (commits),
    .o_stalls     (stalls)
  );

  always #50 i_clk = ~i_clk;

  // renamer bookkeeping at mid cycle, where the bus is stable
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      busy    = '0;
      next_id = '0;
      for (int i = 0; i < 16; i++) readers[i] = 0;
    end else begin
      if (wb.valid) begin
        busy[wb.rd] = 1'b0;
        readers[src1[wb.cmt_id]]--;  // operands already latched
        readers[src2[wb.cmt_id]]--;
      end
      if (disp_valid && disp_ready) begin
        busy[disp.rd] = 1'b1;
        readers[disp.rs1]++;
        readers[disp.rs2]++;
        src1[next_id] = disp.rs1;
        src2[next_id] = disp.rs2;
        next_id++;
      end
    end
  end

  // ready flags are refreshed every cycle while held
  task automatic dispatch_line(input logic [19:0] line, input logic last);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      disp.op        = sched_pkg::op_t'(line[13:12]);
      disp.rd        = line[11:8];
      disp.rs1       = line[7:4];
      disp.rs2       = line[3:0];
      disp.rs1_ready = !busy[line[7:4]];
      disp.rs2_ready = !busy[line[3:0]];
      disp_test      = line[19:16];
      disp_last      = last;
      disp_valid     = !busy[line[11:8]] && (readers[line[11:8]] == 0);  // no waw or war
      @(negedge i_clk);
      accepted = disp_valid && disp_ready;
      @(posedge i_clk);
      #1;
    end
    disp_valid = 1'b0;
  endtask

  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cycles++;
      if (cycles > limit) begin
        $display("timeout: run still busy after %0d cycles, %0d of %0d committed",
                 limit, commits, num_lines);
        $display("Some tests failed");
        $finish;
      end
    end
  end

  initial begin
    int gap;
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    disp_valid = 1'b0;
    disp       = '0;
    disp_test  = '0;
    disp_last  = 1'b0;
    cycles     = 0;
    seed       = 94;
    for (int i = 0; i < MAX_LINES; i++) lines[i] = '0;
    $readmemh("tests/sched_input.txt", lines);
    num_lines = 0;
    while (num_lines < MAX_LINES && lines[num_lines][19:16] != 4'h0) num_lines++;
    limit = 20 * num_lines + 100;

    repeat (4) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    for (int i = 0; i < num_lines; i++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) begin
        @(posedge i_clk);
        #1;
      end
      dispatch_line(lines[i], (i == num_lines - 1) || (lines[i+1][19:16] != lines[i][19:16]));
    end

    while (commits < num_lines) @(posedge i_clk);
    repeat (4) @(posedge i_clk);  // catch stray traffic

    if (stalls == 0) $display("dispatch was never held back by a full queue");
    if (commits != num_lines) begin
      $display("commit count %0d does not match %0d dispatched", commits, num_lines);
    end
    $display("tests ok: %0d, tests failing: %0d, errors: %0d", tests_pass, tests_fail, errors);
    if (errors == 0 && stalls > 0 && commits == num_lines && tests_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/sched_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_checker (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_disp_valid,
  input  logic               i_disp_ready,
  input  sched_pkg::disp_t   i_disp,
  input  logic [3:0]         i_test,
  input  logic               i_last,
  input  sched_pkg::wb_t     i_wb,
  input  sched_pkg::commit_t i_commit,
  output int                 o_errors,
  output int                 o_tests_pass,
  output int                 o_tests_fail,
  output int                 o_commits,
  output int                 o_stalls
);

  localparam int MAX_SEQ = 256;

  logic [15:0] ref_regs [16];
  logic [15:0] exp_data [MAX_SEQ];
  logic [3:0]  exp_rd [MAX_SEQ];
  logic [3:0]  seq_test [MAX_SEQ];
  logic        seq_last [MAX_SEQ];
  int          wb_cycle [MAX_SEQ];  // -1 until written back
  int          id_seq [8];          // commit id to dispatch order
  logic        test_bad [16];
  int          disp_count;
  int          cycle;
  logic        after_reset;

  function automatic logic [15:0] alu_ref(input logic [1:0] op, input logic [15:0] a,
                                          input logic [15:0] b);
    case (op)
      2'd0:    return a + b;
      2'd1:    return a - b;  // wraps mod 2^16
      2'd2:    return a ^ b;
      default: return a & b;
    endcase
  endfunction

  task automatic report(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    o_errors++;
  endtask

  task automatic check_idle();
    if (i_wb.valid) report("writeback valid during reset");
    if (i_commit.valid) report("commit valid during reset");
    if (!i_disp_ready) report("dispatch not ready during reset");
  endtask

  always @(negedge i_clk) begin
    int seq;
    if (!i_reset_n) begin
      for (int i = 0; i < 16; i++) begin
        ref_regs[i] = 16'(i);
        test_bad[i] = 1'b0;
      end
      for (int i = 0; i < 8; i++) id_seq[i] = -1;
      disp_count  = 0;
      cycle       = 0;
      o_commits   = 0;
      o_stalls    = 0;
      after_reset = 1'b1;
      check_idle();
    end else begin
      if (after_reset) check_idle();
      after_reset = 1'b0;
      cycle++;
      if (i_disp_valid && !i_disp_ready) o_stalls++;

      if (i_disp_valid && i_disp_ready && disp_count < MAX_SEQ) begin
        seq                 = disp_count;
        exp_data[seq]       = alu_ref(i_disp.op, ref_regs[i_disp.rs1], ref_regs[i_disp.rs2]);
        ref_regs[i_disp.rd] = exp_data[seq];
        exp_rd[seq]         = i_disp.rd;
        seq_test[seq]       = i_test;
        seq_last[seq]       = i_last;
        wb_cycle[seq]       = -1;
        id_seq[seq % 8]     = seq;
        disp_count++;
      end

      if (i_wb.valid) begin
        seq = id_seq[i_wb.cmt_id];
        if (seq < 0 || wb_cycle[seq] != -1) begin
          report($sformatf("unexpected writeback for commit id %0d", i_wb.cmt_id));
        end else begin
          wb_cycle[seq] = cycle;
          if (i_wb.rd != exp_rd[seq] || i_wb.data != exp_data[seq]) begin
            report($sformatf("instr %0d wrote r%0d=%h, expected r%0d=%h", seq, i_wb.rd,
                             i_wb.data, exp_rd[seq], exp_data[seq]));
            test_bad[seq_test[seq]] = 1'b1;
          end
        end
      end

      if (i_commit.valid) begin
        seq = o_commits;
        if (seq >= disp_count) begin
          report("commit with no instruction in flight");
        end else begin
          if (i_commit.cmt_id != o_commits[2:0]) begin
            report($sformatf("commit id %0d out of order, expected %0d",
                             i_commit.cmt_id, o_commits[2:0]));
            test_bad[seq_test[seq]] = 1'b1;
          end else if (wb_cycle[seq] < 0 || wb_cycle[seq] >= cycle) begin
            report($sformatf("instr %0d committed before its writeback", seq));
            test_bad[seq_test[seq]] = 1'b1;
          end
          id_seq[i_commit.cmt_id] = -1;
          if (seq_last[seq]) begin
            if (test_bad[seq_test[seq]]) o_tests_fail++;
            else o_tests_pass++;
            $display("test %0d: %s", seq_test[seq], test_bad[seq_test[seq]] ? "FAIL" : "ok");
          end
        end
        o_commits++;  // every pulse counts, stray ones too
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_top (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_disp_valid,
  input  sched_pkg::disp_t   i_disp,
  output logic               o_disp_ready,
  output sched_pkg::wb_t     o_wb,
  output sched_pkg::commit_t o_commit
);

  logic                           w_has_free;
  logic                           w_not_full;
  logic [sched_pkg::CMT_ID_W-1:0] w_alloc_id;
  logic [sched_pkg::CMT_ID_W-1:0] w_head_id;
  sched_pkg::issue_t              w_issue;
  logic [sched_pkg::RNID_W-1:0]   w_rs1;
  logic [sched_pkg::RNID_W-1:0]   w_rs2;
  logic [sched_pkg::DATA_W-1:0]   w_rs1_data;
  logic [sched_pkg::DATA_W-1:0]   w_rs2_data;

  assign o_disp_ready = w_has_free & w_not_full;

  issue_queue queue_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp       (i_disp),
    .i_disp_ready (o_disp_ready),
    .i_cmt_id     (w_alloc_id),
    .i_head_id    (w_head_id),
    .i_wb         (o_wb),
    .i_commit     (o_commit),
    .o_has_free   (w_has_free),
    .o_issue      (w_issue)
  );

  alu_pipe pipe_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (w_issue),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .o_rs1      (w_rs1),
    .o_rs2      (w_rs2),
    .o_wb       (o_wb)
  );

  phys_regfile regfile_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rs1      (w_rs1),
    .i_rs2      (w_rs2),
    .i_wb       (o_wb),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data)
  );

  commit_unit commit_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_alloc    (i_disp_valid & o_disp_ready),  // accepted dispatch
    .i_wb       (o_wb),
    .o_alloc_id (w_alloc_id),
    .o_head_id  (w_head_id),
    .o_not_full (w_not_full),
    .o_commit   (o_commit)
  );

endmodule

`default_nettype wire

// ==== rtl/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_alloc,
  input  sched_pkg::wb_t                 i_wb,
  output logic [sched_pkg::CMT_ID_W-1:0] o_alloc_id,
  output logic [sched_pkg::CMT_ID_W-1:0] o_head_id,
  output logic                           o_not_full,
  output sched_pkg::commit_t             o_commit
);

  // extra msb tells full from empty
  logic [sched_pkg::CMT_ID_W:0]    r_head;
  logic [sched_pkg::CMT_ID_W:0]    r_tail;
  logic [sched_pkg::CMT_NUM-1:0]   r_done;
  logic [sched_pkg::CMT_ID_W:0]    w_used;
  logic                            w_retire;

  assign o_alloc_id = r_tail[sched_pkg::CMT_ID_W-1:0];
  assign o_head_id  = r_head[sched_pkg::CMT_ID_W-1:0];
  assign w_used     = r_tail - r_head;
  assign o_not_full = (w_used != (sched_pkg::CMT_ID_W + 1)'(sched_pkg::CMT_NUM));
  assign w_retire   = r_done[o_head_id];

  assign o_commit.valid  = w_retire;
  assign o_commit.cmt_id = o_head_id;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
      r_done <= '0;
    end else begin
      if (i_alloc) r_tail <= r_tail + 1'b1;
      if (w_retire) begin
        r_head            <= r_head + 1'b1;
        r_done[o_head_id] <= 1'b0;
      end
      if (i_wb.valid) r_done[i_wb.cmt_id] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic [sched_pkg::RNID_W-1:0] i_rs1,
  input  logic [sched_pkg::RNID_W-1:0] i_rs2,
  input  sched_pkg::wb_t               i_wb,
  output logic [sched_pkg::DATA_W-1:0] o_rs1_data,
  output logic [sched_pkg::DATA_W-1:0] o_rs2_data
);

  logic [sched_pkg::DATA_W-1:0] r_regs [sched_pkg::PREG_NUM];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < sched_pkg::PREG_NUM; i++) begin
        r_regs[i] <= sched_pkg::DATA_W'(i);  // reg n starts at n
      end
    end else if (i_wb.valid) begin
      r_regs[i_wb.rd] <= i_wb.data;
    end
  end

  assign o_rs1_data = r_regs[i_rs1];
  assign o_rs2_data = r_regs[i_rs2];

endmodule

`default_nettype wire

// ==== rtl/alu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  sched_pkg::issue_t            i_issue,
  input  logic [sched_pkg::DATA_W-1:0] i_rs1_data,
  input  logic [sched_pkg::DATA_W-1:0] i_rs2_data,
  output logic [sched_pkg::RNID_W-1:0] o_rs1,
  output logic [sched_pkg::RNID_W-1:0] o_rs2,
  output sched_pkg::wb_t               o_wb
);

  sched_pkg::issue_t            r_ex1;
  logic [sched_pkg::DATA_W-1:0] r_op1;
  logic [sched_pkg::DATA_W-1:0] r_op2;
  logic [sched_pkg::DATA_W-1:0] w_fwd1;
  logic [sched_pkg::DATA_W-1:0] w_fwd2;
  logic [sched_pkg::DATA_W-1:0] w_result;

  assign o_rs1 = i_issue.rs1;
  assign o_rs2 = i_issue.rs2;

  // regfile write lands next cycle, so bypass it
  assign w_fwd1 = (o_wb.valid && (o_wb.rd == i_issue.rs1)) ? o_wb.data : i_rs1_data;
  assign w_fwd2 = (o_wb.valid && (o_wb.rd == i_issue.rs2)) ? o_wb.data : i_rs2_data;

  always_ff @(posedge i_clk) begin
    r_op1 <= w_fwd1;
    r_op2 <= w_fwd2;
  end

  always_comb begin
    case (r_ex1.op)
      sched_pkg::ADD: w_result = r_op1 + r_op2;
      sched_pkg::SUB: w_result = r_op1 - r_op2;
      sched_pkg::XOR: w_result = r_op1 ^ r_op2;
      default:        w_result = r_op1 & r_op2;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1 <= '0;
      o_wb  <= '0;
    end else begin
      r_ex1       <= i_issue;  // stage one
      o_wb.valid  <= r_ex1.valid;  // stage two is the writeback
      o_wb.rd     <= r_ex1.rd;
      o_wb.data   <= w_result;
      o_wb.cmt_id <= r_ex1.cmt_id;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_disp_valid,
  input  sched_pkg::disp_t               i_disp,
  input  logic                           i_disp_ready,
  input  logic [sched_pkg::CMT_ID_W-1:0] i_cmt_id,
  input  logic [sched_pkg::CMT_ID_W-1:0] i_head_id,
  input  sched_pkg::wb_t                 i_wb,
  input  sched_pkg::commit_t             i_commit,
  output logic                           o_has_free,
  output sched_pkg::issue_t              o_issue
);

  logic [sched_pkg::ENTRY_NUM-1:0]   w_valid;
  logic [sched_pkg::ENTRY_NUM-1:0]   w_ready;
  logic [sched_pkg::ENTRY_NUM-1:0]   w_put;
  logic [sched_pkg::ENTRY_NUM-1:0]   w_picked;
  sched_pkg::issue_t                 w_entry [sched_pkg::ENTRY_NUM];
  logic [sched_pkg::CMT_ID_W-1:0]    w_cmt_id [sched_pkg::ENTRY_NUM];
  logic [sched_pkg::CMT_ID_W-1:0]    w_age [sched_pkg::ENTRY_NUM];
  logic [sched_pkg::ENTRY_IDX_W-1:0] w_free_idx;
  logic [sched_pkg::ENTRY_IDX_W-1:0] w_pick_idx;
  logic                              w_pick_valid;
  logic [sched_pkg::CMT_ID_W-1:0]    w_best_age;

  assign o_has_free = ~&w_valid;

  // lowest free slot wins
  always_comb begin
    w_free_idx = '0;
    for (int i = sched_pkg::ENTRY_NUM - 1; i >= 0; i--) begin
      if (!w_valid[i]) w_free_idx = sched_pkg::ENTRY_IDX_W'(i);
    end
  end

  // oldest ready relative to the commit head
  always_comb begin
    w_pick_valid = 1'b0;
    w_pick_idx   = '0;
    w_best_age   = '1;
    for (int i = 0; i < sched_pkg::ENTRY_NUM; i++) begin
      if (w_ready[i] && (!w_pick_valid || (w_age[i] < w_best_age))) begin
        w_pick_valid = 1'b1;
        w_pick_idx   = sched_pkg::ENTRY_IDX_W'(i);
        w_best_age   = w_age[i];
      end
    end
  end

  for (genvar g = 0; g < sched_pkg::ENTRY_NUM; g++) begin : g_entry
    assign w_put[g]    = i_disp_valid & i_disp_ready &
                         (w_free_idx == sched_pkg::ENTRY_IDX_W'(g));
    assign w_picked[g] = w_pick_valid & (w_pick_idx == sched_pkg::ENTRY_IDX_W'(g));
    assign w_age[g]    = w_cmt_id[g] - i_head_id;  // wraps mod 8

    sched_entry entry_i (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_put      (w_put[g]),
      .i_cmt_id   (i_cmt_id),
      .i_put_data (i_disp),
      .i_wb       (i_wb),
      .i_commit   (i_commit),
      .i_picked   (w_picked[g]),
      .o_valid    (w_valid[g]),
      .o_ready    (w_ready[g]),
      .o_entry    (w_entry[g]),
      .o_cmt_id   (w_cmt_id[g])
    );
  end

  // the picked entry is ready, so its own valid is the issue valid
  assign o_issue = w_entry[w_pick_idx];

endmodule

`default_nettype wire

// ==== rtl/sched_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module sched_entry (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_put,
  input  logic [sched_pkg::CMT_ID_W-1:0] i_cmt_id,
  input  sched_pkg::disp_t               i_put_data,
  input  sched_pkg::wb_t                 i_wb,
  input  sched_pkg::commit_t             i_commit,
  input  logic                           i_picked,
  output logic                           o_valid,
  output logic                           o_ready,
  output sched_pkg::issue_t              o_entry,
  output logic [sched_pkg::CMT_ID_W-1:0] o_cmt_id
);

  sched_pkg::sched_state_t          r_state;
  sched_pkg::disp_t                 r_inst;
  logic [sched_pkg::CMT_ID_W-1:0]   r_cmt_id;

  logic [sched_pkg::RNID_W-1:0] w_rs1;
  logic [sched_pkg::RNID_W-1:0] w_rs2;
  logic                         w_rs1_hit;
  logic                         w_rs2_hit;
  logic                         w_rs1_ready;
  logic                         w_rs2_ready;
  logic                         w_wb_done;
  logic                         w_commit_hit;

  // snoop with the incoming sources on the put cycle
  assign w_rs1 = i_put ? i_put_data.rs1 : r_inst.rs1;
  assign w_rs2 = i_put ? i_put_data.rs2 : r_inst.rs2;

  assign w_rs1_hit = i_wb.valid & (i_wb.rd == w_rs1);
  assign w_rs2_hit = i_wb.valid & (i_wb.rd == w_rs2);

  assign w_rs1_ready = r_inst.rs1_ready | w_rs1_hit;
  assign w_rs2_ready = r_inst.rs2_ready | w_rs2_hit;

  assign w_wb_done    = i_wb.valid & (i_wb.cmt_id == r_cmt_id);
  assign w_commit_hit = i_commit.valid & (i_commit.cmt_id == r_cmt_id);

  always_ff @(posedge i_clk) begin
    if (i_put && (r_state == sched_pkg::INIT)) begin
      r_inst           <= i_put_data;
      r_inst.rs1_ready <= i_put_data.rs1_ready | w_rs1_hit;
      r_inst.rs2_ready <= i_put_data.rs2_ready | w_rs2_hit;
      r_cmt_id         <= i_cmt_id;
    end else if (r_state == sched_pkg::WAIT) begin
      r_inst.rs1_ready <= w_rs1_ready;  // wakeup
      r_inst.rs2_ready <= w_rs2_ready;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= sched_pkg::INIT;
    end else begin
      case (r_state)
        sched_pkg::INIT: begin
          if (i_put) r_state <= sched_pkg::WAIT;
        end
        sched_pkg::WAIT: begin
          if (i_picked) r_state <= sched_pkg::ISSUED;
        end
        sched_pkg::ISSUED: begin
          if (w_wb_done) r_state <= sched_pkg::DONE;
        end
        sched_pkg::DONE: begin
          if (w_commit_hit) r_state <= sched_pkg::INIT;  // slot freed
        end
        default: r_state <= sched_pkg::INIT;
      endcase
    end
  end

  assign o_valid  = (r_state != sched_pkg::INIT);
  assign o_ready  = (r_state == sched_pkg::WAIT) & w_rs1_ready & w_rs2_ready;
  assign o_cmt_id = r_cmt_id;

  always_comb begin
    o_entry.valid  = o_ready;
    o_entry.op     = r_inst.op;
    o_entry.rd     = r_inst.rd;
    o_entry.rs1    = r_inst.rs1;
    o_entry.rs2    = r_inst.rs2;
    o_entry.cmt_id = r_cmt_id;
  end

endmodule

`default_nettype wire

// ==== rtl/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  localparam int ENTRY_NUM   = 4;
  localparam int ENTRY_IDX_W = $clog2(ENTRY_NUM);
  localparam int RNID_W      = 4;
  localparam int PREG_NUM    = 1 << RNID_W;
  localparam int CMT_ID_W    = 3;
  localparam int CMT_NUM     = 1 << CMT_ID_W;  // instructions in flight
  localparam int DATA_W      = 16;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    XOR = 2'd2,
    AND = 2'd3
  } op_t;

  typedef enum logic [1:0] {
    INIT   = 2'd0,  // free
    WAIT   = 2'd1,
    ISSUED = 2'd2,
    DONE   = 2'd3   // written back, not yet retired
  } sched_state_t;

  typedef struct packed {
    op_t               op;
    logic [RNID_W-1:0] rd;
    logic [RNID_W-1:0] rs1;
    logic              rs1_ready;
    logic [RNID_W-1:0] rs2;
    logic              rs2_ready;
  } disp_t;

  typedef struct packed {
    logic                valid;
    op_t                 op;
    logic [RNID_W-1:0]   rd;
    logic [RNID_W-1:0]   rs1;
    logic [RNID_W-1:0]   rs2;
    logic [CMT_ID_W-1:0] cmt_id;
  } issue_t;

  typedef struct packed {
    logic                valid;
    logic [RNID_W-1:0]   rd;
    logic [DATA_W-1:0]   data;
    logic [CMT_ID_W-1:0] cmt_id;
  } wb_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } commit_t;

endpackage

`default_nettype wire
